// ==== design/rv_isa_pkg.sv ====
// base ISA word, opcode and format types, funct codes and fixed register numbers
package rv_isa_pkg;

	// full 32-bit instruction word
	typedef logic [31:0] insn_t;

	// major opcode, bits 6:2 of the word
	typedef enum logic [4:0] {
		op_load   = 5'b00000,
		op_op_imm = 5'b00100,
		op_store  = 5'b01000,
		op_op     = 5'b01100,
		op_lui    = 5'b01101,
		op_branch = 5'b11000,
		op_jalr   = 5'b11001,
		op_jal    = 5'b11011,
		op_system = 5'b11100
	} opcode_e;

	// field layout of the word
	typedef enum logic [2:0] {
		fmt_r,
		fmt_i,
		fmt_s,
		fmt_b,
		fmt_u,
		fmt_j
	} format_e;

	typedef logic [4:0] reg_t;

	// right-aligned immediate
	// I and S hold imm[11:0], B holds offset[12:1]
	// U holds imm[31:12], J holds offset[20:1]
	typedef logic [19:0] imm_t;

	localparam reg_t reg_zero = 5'd0;
	localparam reg_t reg_ra   = 5'd1;
	localparam reg_t reg_sp   = 5'd2;

	// funct3 values
	localparam logic [2:0] f3_add = 3'b000;
	localparam logic [2:0] f3_sll = 3'b001;
	localparam logic [2:0] f3_lw  = 3'b010;
	localparam logic [2:0] f3_sw  = 3'b010;
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_srl = 3'b101;
	localparam logic [2:0] f3_or  = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;
	localparam logic [2:0] f3_beq = 3'b000;
	localparam logic [2:0] f3_bne = 3'b001;

	// funct7, alt sets the sub/sra bit
	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt  = 7'b0100000;

	// low bits of every uncompressed word
	localparam logic [1:0] insn_lsb = 2'b11;

endpackage

// ==== design/rvc_pkg.sv ====
// compressed quadrant codes, compressed funct3 slots and the prime register prefix
package rvc_pkg;

	// bits 1:0 of a 16-bit parcel
	typedef enum logic [1:0] {
		q0     = 2'b00,
		q1     = 2'b01,
		q2     = 2'b10,
		q_full = 2'b11
	} quadrant_e;

	// bits 15:13, each slot named q0_q1_q2
	// fp slots and zcb are not supported here
	typedef enum logic [2:0] {
		c3_addi4spn_addi_slli = 3'b000,
		c3_fld_jal_fldsp      = 3'b001,
		c3_lw_li_lwsp         = 3'b010,
		c3_flw_lui_flwsp      = 3'b011,
		c3_zcb_alu_jr         = 3'b100,
		c3_fsd_j_fsdsp        = 3'b101,
		c3_sw_beqz_swsp       = 3'b110,
		c3_fsw_bnez_fswsp     = 3'b111
	} c_funct3_e;

	// 3-bit prime register maps onto x8..x15
	localparam logic [1:0] creg_base = 2'b01;

endpackage

// ==== design/rvc_quadrant0.sv ====
// quadrant 0 expansion: stack pointer add, word load and word store
`timescale 1ns/1ns

module rvc_quadrant0 (
	input  logic [15:0]         c_insn_i,
	output rv_isa_pkg::format_e fmt_o,
	output rv_isa_pkg::opcode_e opcode_o,
	output rv_isa_pkg::reg_t    rd_o,
	output rv_isa_pkg::reg_t    rs1_o,
	output rv_isa_pkg::reg_t    rs2_o,
	output logic [2:0]          funct3_o,
	output logic [6:0]          funct7_o,
	output rv_isa_pkg::imm_t    imm_o,
	output logic                illegal_o
);
	rvc_pkg::c_funct3_e slot;
	// rd' and rs2' share bits 4:2
	rv_isa_pkg::reg_t lo_p;
	rv_isa_pkg::reg_t rs1_p;
	// word offset for lw and sw, uimm[6:2]
	rv_isa_pkg::imm_t word_ofs;
	// nzuimm[9:2] of addi4spn
	rv_isa_pkg::imm_t sp_ofs;

	assign slot = rvc_pkg::c_funct3_e'(c_insn_i[15:13]);
	assign lo_p = {rvc_pkg::creg_base, c_insn_i[4:2]};
	assign rs1_p = {rvc_pkg::creg_base, c_insn_i[9:7]};
	assign word_ofs = {13'b0, c_insn_i[5], c_insn_i[12:10], c_insn_i[6], 2'b00};
	assign sp_ofs = {10'b0, c_insn_i[10:7], c_insn_i[12:11], c_insn_i[5], c_insn_i[6], 2'b00};

	always_comb begin
		fmt_o = rv_isa_pkg::fmt_i;
		opcode_o = rv_isa_pkg::op_op_imm;
		rd_o = rv_isa_pkg::reg_zero;
		rs1_o = rv_isa_pkg::reg_zero;
		rs2_o = rv_isa_pkg::reg_zero;
		funct3_o = rv_isa_pkg::f3_add;
		funct7_o = rv_isa_pkg::f7_base;
		imm_o = '0;
		illegal_o = 1'b0;
		unique case (slot)
			// addi4spn, zero immediate is reserved and covers the all-zero parcel
			rvc_pkg::c3_addi4spn_addi_slli: begin
				rd_o = lo_p;
				rs1_o = rv_isa_pkg::reg_sp;
				imm_o = sp_ofs;
				illegal_o = (c_insn_i[12:5] == 8'd0);
			end
			// lw
			rvc_pkg::c3_lw_li_lwsp: begin
				opcode_o = rv_isa_pkg::op_load;
				rd_o = lo_p;
				rs1_o = rs1_p;
				funct3_o = rv_isa_pkg::f3_lw;
				imm_o = word_ofs;
			end
			// sw
			rvc_pkg::c3_sw_beqz_swsp: begin
				fmt_o = rv_isa_pkg::fmt_s;
				opcode_o = rv_isa_pkg::op_store;
				rs1_o = rs1_p;
				rs2_o = lo_p;
				funct3_o = rv_isa_pkg::f3_sw;
				imm_o = word_ofs;
			end
			// fp loads/stores and zcb slot
			default: illegal_o = 1'b1;
		endcase
	end

endmodule

// ==== design/rvc_quadrant1.sv ====
// quadrant 1 expansion: immediates, jumps, alu group and compare-with-zero branches
`timescale 1ns/1ns

module rvc_quadrant1 (
	input  logic [15:0]         c_insn_i,
	output rv_isa_pkg::format_e fmt_o,
	output rv_isa_pkg::opcode_e opcode_o,
	output rv_isa_pkg::reg_t    rd_o,
	output rv_isa_pkg::reg_t    rs1_o,
	output rv_isa_pkg::reg_t    rs2_o,
	output logic [2:0]          funct3_o,
	output logic [6:0]          funct7_o,
	output rv_isa_pkg::imm_t    imm_o,
	output logic                illegal_o
);
	rvc_pkg::c_funct3_e slot;
	rv_isa_pkg::reg_t rd_full;
	rv_isa_pkg::reg_t rs1_p;
	rv_isa_pkg::reg_t rs2_p;
	// 6-bit signed immediate, same extension serves I and U
	rv_isa_pkg::imm_t imm6_sx;
	// offset[20:1] for jal and j
	rv_isa_pkg::imm_t jump_ofs;
	// offset[12:1] for beqz and bnez
	rv_isa_pkg::imm_t branch_ofs;
	// nzimm[9:4] of addi16sp
	rv_isa_pkg::imm_t sp16_ofs;
	// srli or srai upper immediate bits
	logic [6:0] shift_f7;

	assign slot = rvc_pkg::c_funct3_e'(c_insn_i[15:13]);
	assign rd_full = c_insn_i[11:7];
	assign rs1_p = {rvc_pkg::creg_base, c_insn_i[9:7]};
	assign rs2_p = {rvc_pkg::creg_base, c_insn_i[4:2]};
	assign imm6_sx = {{14{c_insn_i[12]}}, c_insn_i[12], c_insn_i[6:2]};
	assign jump_ofs = {{9{c_insn_i[12]}}, c_insn_i[12], c_insn_i[8], c_insn_i[10:9],
		c_insn_i[6], c_insn_i[7], c_insn_i[2], c_insn_i[11], c_insn_i[5:3]};
	assign branch_ofs = {{12{c_insn_i[12]}}, c_insn_i[12], c_insn_i[6:5], c_insn_i[2],
		c_insn_i[11:10], c_insn_i[4:3]};
	assign sp16_ofs = {{10{c_insn_i[12]}}, c_insn_i[12], c_insn_i[4:3], c_insn_i[5],
		c_insn_i[2], c_insn_i[6], 4'b0000};
	assign shift_f7 = c_insn_i[10] ? rv_isa_pkg::f7_alt : rv_isa_pkg::f7_base;

	always_comb begin
		fmt_o = rv_isa_pkg::fmt_i;
		opcode_o = rv_isa_pkg::op_op_imm;
		rd_o = rv_isa_pkg::reg_zero;
		rs1_o = rv_isa_pkg::reg_zero;
		rs2_o = rv_isa_pkg::reg_zero;
		funct3_o = rv_isa_pkg::f3_add;
		funct7_o = rv_isa_pkg::f7_base;
		imm_o = '0;
		illegal_o = 1'b0;
		unique case (slot)
			// addi and li, li reads x0
			rvc_pkg::c3_addi4spn_addi_slli, rvc_pkg::c3_lw_li_lwsp: begin
				rd_o = rd_full;
				rs1_o = c_insn_i[14] ? rv_isa_pkg::reg_zero : rd_full;
				imm_o = imm6_sx;
			end
			// jal links to ra, j discards the link
			rvc_pkg::c3_fld_jal_fldsp, rvc_pkg::c3_fsd_j_fsdsp: begin
				fmt_o = rv_isa_pkg::fmt_j;
				opcode_o = rv_isa_pkg::op_jal;
				rd_o = c_insn_i[15] ? rv_isa_pkg::reg_zero : rv_isa_pkg::reg_ra;
				imm_o = jump_ofs;
			end
			// addi16sp when rd is sp, lui otherwise
			rvc_pkg::c3_flw_lui_flwsp: begin
				rd_o = rd_full;
				if (rd_full == rv_isa_pkg::reg_sp) begin
					rs1_o = rv_isa_pkg::reg_sp;
					imm_o = sp16_ofs;
				end else begin
					fmt_o = rv_isa_pkg::fmt_u;
					opcode_o = rv_isa_pkg::op_lui;
					imm_o = imm6_sx;
				end
			end
			// shifts, andi and register alu ops on prime regs
			rvc_pkg::c3_zcb_alu_jr: begin
				rd_o = rs1_p;
				rs1_o = rs1_p;
				unique case (c_insn_i[11:10])
					// srli, srai, shamt[5] goes through as is
					2'b00, 2'b01: begin
						funct3_o = rv_isa_pkg::f3_srl;
						imm_o = {8'b0, shift_f7[6:1], c_insn_i[12], c_insn_i[6:2]};
					end
					2'b10: begin
						funct3_o = rv_isa_pkg::f3_and;
						imm_o = imm6_sx;
					end
					2'b11: begin
						fmt_o = rv_isa_pkg::fmt_r;
						opcode_o = rv_isa_pkg::op_op;
						rs2_o = rs2_p;
						// subw, addw and the two reserved codes
						illegal_o = c_insn_i[12];
						unique case (c_insn_i[6:5])
							2'b00: funct7_o = rv_isa_pkg::f7_alt;
							2'b01: funct3_o = rv_isa_pkg::f3_xor;
							2'b10: funct3_o = rv_isa_pkg::f3_or;
							2'b11: funct3_o = rv_isa_pkg::f3_and;
						endcase
					end
				endcase
			end
			// beqz, bnez against x0
			rvc_pkg::c3_sw_beqz_swsp, rvc_pkg::c3_fsw_bnez_fswsp: begin
				fmt_o = rv_isa_pkg::fmt_b;
				opcode_o = rv_isa_pkg::op_branch;
				rs1_o = rs1_p;
				funct3_o = c_insn_i[13] ? rv_isa_pkg::f3_bne : rv_isa_pkg::f3_beq;
				imm_o = branch_ofs;
			end
		endcase
	end

endmodule

// ==== design/rvc_quadrant2.sv ====
// quadrant 2 expansion: slli, stack word load/store, jr/jalr/mv/add and ebreak
`timescale 1ns/1ns

module rvc_quadrant2 (
	input  logic [15:0]         c_insn_i,
	output rv_isa_pkg::format_e fmt_o,
	output rv_isa_pkg::opcode_e opcode_o,
	output rv_isa_pkg::reg_t    rd_o,
	output rv_isa_pkg::reg_t    rs1_o,
	output rv_isa_pkg::reg_t    rs2_o,
	output logic [2:0]          funct3_o,
	output logic [6:0]          funct7_o,
	output rv_isa_pkg::imm_t    imm_o,
	output logic                illegal_o
);
	rvc_pkg::c_funct3_e slot;
	rv_isa_pkg::reg_t rd_full;
	rv_isa_pkg::reg_t rs2_full;
	// register-zero pattern picks the group member
	logic rd_nz;
	logic rs2_nz;

	assign slot = rvc_pkg::c_funct3_e'(c_insn_i[15:13]);
	assign rd_full = c_insn_i[11:7];
	assign rs2_full = c_insn_i[6:2];
	assign rd_nz = (rd_full != rv_isa_pkg::reg_zero);
	assign rs2_nz = (rs2_full != rv_isa_pkg::reg_zero);

	always_comb begin
		fmt_o = rv_isa_pkg::fmt_i;
		opcode_o = rv_isa_pkg::op_op_imm;
		rd_o = rv_isa_pkg::reg_zero;
		rs1_o = rv_isa_pkg::reg_zero;
		rs2_o = rv_isa_pkg::reg_zero;
		funct3_o = rv_isa_pkg::f3_add;
		funct7_o = rv_isa_pkg::f7_base;
		imm_o = '0;
		illegal_o = 1'b0;
		unique case (slot)
			// slli
			rvc_pkg::c3_addi4spn_addi_slli: begin
				rd_o = rd_full;
				rs1_o = rd_full;
				funct3_o = rv_isa_pkg::f3_sll;
				imm_o = {8'b0, rv_isa_pkg::f7_base[6:1], c_insn_i[12], c_insn_i[6:2]};
			end
			// lwsp, uimm[7:2]
			rvc_pkg::c3_lw_li_lwsp: begin
				opcode_o = rv_isa_pkg::op_load;
				rd_o = rd_full;
				rs1_o = rv_isa_pkg::reg_sp;
				funct3_o = rv_isa_pkg::f3_lw;
				imm_o = {12'b0, c_insn_i[3:2], c_insn_i[12], c_insn_i[6:4], 2'b00};
			end
			// swsp, uimm[7:2]
			rvc_pkg::c3_sw_beqz_swsp: begin
				fmt_o = rv_isa_pkg::fmt_s;
				opcode_o = rv_isa_pkg::op_store;
				rs1_o = rv_isa_pkg::reg_sp;
				rs2_o = rs2_full;
				funct3_o = rv_isa_pkg::f3_sw;
				imm_o = {12'b0, c_insn_i[8:7], c_insn_i[12:9], 2'b00};
			end
			rvc_pkg::c3_zcb_alu_jr: begin
				unique case ({rd_nz, rs2_nz})
					// ebreak with bit 12, reserved without
					// priv funct3 and registers stay zero
					2'b00: begin
						if (c_insn_i[12]) begin
							opcode_o = rv_isa_pkg::op_system;
							imm_o = 20'd1;
						end else begin
							illegal_o = 1'b1;
						end
					end
					// no destination for mv/add
					2'b01: illegal_o = 1'b1;
					// jr, jalr links to ra
					2'b10: begin
						opcode_o = rv_isa_pkg::op_jalr;
						rd_o = c_insn_i[12] ? rv_isa_pkg::reg_ra : rv_isa_pkg::reg_zero;
						rs1_o = rd_full;
					end
					// mv adds to x0, add reads rd
					2'b11: begin
						fmt_o = rv_isa_pkg::fmt_r;
						opcode_o = rv_isa_pkg::op_op;
						rd_o = rd_full;
						rs1_o = c_insn_i[12] ? rd_full : rv_isa_pkg::reg_zero;
						rs2_o = rs2_full;
					end
				endcase
			end
			// fp stack slots
			default: illegal_o = 1'b1;
		endcase
	end

endmodule

// ==== design/rv_insn_encoder.sv ====
// field packing for the R, I, S, B, U and J instruction layouts
`timescale 1ns/1ns

module rv_insn_encoder (
	input  rv_isa_pkg::format_e fmt_i,
	input  rv_isa_pkg::opcode_e opcode_i,
	input  rv_isa_pkg::reg_t    rd_i,
	input  rv_isa_pkg::reg_t    rs1_i,
	input  rv_isa_pkg::reg_t    rs2_i,
	input  logic [2:0]          funct3_i,
	input  logic [6:0]          funct7_i,
	input  rv_isa_pkg::imm_t    imm_i,
	output rv_isa_pkg::insn_t   insn_o
);
	// bits 31:2 of the word
	logic [29:0] body;

	always_comb begin
		unique case (fmt_i)
			rv_isa_pkg::fmt_r: begin
				body = {funct7_i, rs2_i, rs1_i, funct3_i, rd_i, opcode_i};
			end
			rv_isa_pkg::fmt_i: begin
				body = {imm_i[11:0], rs1_i, funct3_i, rd_i, opcode_i};
			end
			// imm[11:5] on top, imm[4:0] in the rd slot
			rv_isa_pkg::fmt_s: begin
				body = {imm_i[11:5], rs2_i, rs1_i, funct3_i, imm_i[4:0], opcode_i};
			end
			// offset 12, 10:5 up top; 4:1, 11 in the rd slot
			rv_isa_pkg::fmt_b: begin
				body = {imm_i[11], imm_i[9:4], rs2_i, rs1_i, funct3_i,
					imm_i[3:0], imm_i[10], opcode_i};
			end
			rv_isa_pkg::fmt_u: begin
				body = {imm_i, rd_i, opcode_i};
			end
			// offset 20, 10:1, 11, 19:12
			rv_isa_pkg::fmt_j: begin
				body = {imm_i[19], imm_i[9:0], imm_i[10], imm_i[18:11], rd_i, opcode_i};
			end
			// unused format codes
			default: body = '0;
		endcase
	end

	assign insn_o = {body, rv_isa_pkg::insn_lsb};

endmodule

// ==== design/rv_decompressor.sv ====
// top-level expander: quadrant select, pass-through of full words, one output register
`timescale 1ns/1ns

module rv_decompressor (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              valid_i,
	input  rv_isa_pkg::insn_t insn_i,
	output logic              valid_o,
	output rv_isa_pkg::insn_t insn_o,
	output logic              illegal_o,
	output logic              compressed_o
);
	// decode results, indexed by quadrant number
	rv_isa_pkg::format_e fmt_dec [3];
	rv_isa_pkg::opcode_e opcode_dec [3];
	rv_isa_pkg::reg_t rd_dec [3];
	rv_isa_pkg::reg_t rs1_dec [3];
	rv_isa_pkg::reg_t rs2_dec [3];
	logic [2:0] funct3_dec [3];
	logic [6:0] funct7_dec [3];
	rv_isa_pkg::imm_t imm_dec [3];
	logic illegal_dec [3];

	rvc_pkg::quadrant_e quadrant;
	logic [1:0] q_idx;
	logic is_comp;
	rv_isa_pkg::insn_t enc_insn;
	rv_isa_pkg::insn_t next_insn;

	assign quadrant = rvc_pkg::quadrant_e'(insn_i[1:0]);
	assign is_comp = (quadrant != rvc_pkg::q_full);

	rvc_quadrant0 u_q0 (
		.c_insn_i(insn_i[15:0]),
		.fmt_o(fmt_dec[0]), .opcode_o(opcode_dec[0]),
		.rd_o(rd_dec[0]), .rs1_o(rs1_dec[0]), .rs2_o(rs2_dec[0]),
		.funct3_o(funct3_dec[0]), .funct7_o(funct7_dec[0]),
		.imm_o(imm_dec[0]), .illegal_o(illegal_dec[0])
	);

	rvc_quadrant1 u_q1 (
		.c_insn_i(insn_i[15:0]),
		.fmt_o(fmt_dec[1]), .opcode_o(opcode_dec[1]),
		.rd_o(rd_dec[1]), .rs1_o(rs1_dec[1]), .rs2_o(rs2_dec[1]),
		.funct3_o(funct3_dec[1]), .funct7_o(funct7_dec[1]),
		.imm_o(imm_dec[1]), .illegal_o(illegal_dec[1])
	);

	rvc_quadrant2 u_q2 (
		.c_insn_i(insn_i[15:0]),
		.fmt_o(fmt_dec[2]), .opcode_o(opcode_dec[2]),
		.rd_o(rd_dec[2]), .rs1_o(rs1_dec[2]), .rs2_o(rs2_dec[2]),
		.funct3_o(funct3_dec[2]), .funct7_o(funct7_dec[2]),
		.imm_o(imm_dec[2]), .illegal_o(illegal_dec[2])
	);

	// full words park on quadrant 0, its result is not used
	always_comb begin
		unique case (quadrant)
			rvc_pkg::q1: q_idx = 2'd1;
			rvc_pkg::q2: q_idx = 2'd2;
			rvc_pkg::q0, rvc_pkg::q_full: q_idx = 2'd0;
		endcase
	end

	rv_insn_encoder u_enc (
		.fmt_i(fmt_dec[q_idx]), .opcode_i(opcode_dec[q_idx]),
		.rd_i(rd_dec[q_idx]), .rs1_i(rs1_dec[q_idx]), .rs2_i(rs2_dec[q_idx]),
		.funct3_i(funct3_dec[q_idx]), .funct7_i(funct7_dec[q_idx]),
		.imm_i(imm_dec[q_idx]), .insn_o(enc_insn)
	);

	// full words unchanged, illegal parcels zeroed
	always_comb begin
		if (!is_comp) begin
			next_insn = insn_i;
		end else if (illegal_dec[q_idx]) begin
			next_insn = '0;
		end else begin
			next_insn = enc_insn;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

	// payload loads only with a valid word, holds otherwise
	always_ff @(posedge clk_i) begin
		if (valid_i) begin
			insn_o <= next_insn;
			illegal_o <= is_comp && illegal_dec[q_idx];
			compressed_o <= is_comp;
		end
	end

endmodule

// ==== tests/tb_clock.sv ====
// free-running testbench clock, 8 ns period
`timescale 1ns/1ns

module tb_clock (
	output logic clk_o
);
	// starts low, first rising edge at 4 ns
	initial begin
		clk_o = 1'b0;
		forever begin
			#4 clk_o = ~clk_o;
		end
	end

endmodule

// ==== tests/rv_decompressor_chk.sv ====
// bound assertions on the expander outputs: reset strobe, legal low bits, zeroed illegal words
`timescale 1ns/1ns

module rv_decompressor_chk (
	input logic              clk_i,
	input logic              rst_i,
	input logic              valid_i,
	input rv_isa_pkg::insn_t insn_i,
	input logic              illegal_i,
	input logic              compressed_i
);
	// reset clears the output strobe
	assert property (@(posedge clk_i) rst_i |=> !valid_i)
		else $error("valid_o still high in the cycle after reset");

	// every legal result is a full-width word
	assert property (@(posedge clk_i) disable iff (rst_i)
		(valid_i && !illegal_i) |-> (insn_i[1:0] == rv_isa_pkg::insn_lsb))
		else $error("legal result without 11 in its low bits");

	// only parcels can be illegal, and they come out as zero
	assert property (@(posedge clk_i) disable iff (rst_i)
		(valid_i && illegal_i) |-> (compressed_i && (insn_i == '0)))
		else $error("illegal result not flagged compressed or not zero");

endmodule

bind rv_decompressor rv_decompressor_chk u_chk (
	.clk_i(clk_i),
	.rst_i(rst_i),
	.valid_i(valid_o),
	.insn_i(insn_o),
	.illegal_i(illegal_o),
	.compressed_i(compressed_o)
);

// ==== tests/tb_rv_decompressor.sv ====
// testbench for the expander: xorshift stimulus, field-rule model, compare tasks, report
`timescale 1ns/1ns

module tb_rv_decompressor;
	// instruction kinds the stimulus picks from
	typedef enum int {
		k_full, k_addi4spn, k_lw, k_sw, k_addi, k_li, k_jal, k_j,
		k_addi16sp, k_lui, k_srli, k_srai, k_andi, k_sub, k_xor, k_or,
		k_and, k_beqz, k_bnez, k_slli, k_lwsp, k_swsp, k_jr, k_jalr,
		k_mv, k_add, k_ebreak, k_illegal
	} kind_e;

	localparam int num_kinds = 28;
	localparam time clk_period = 8;
	// base ISA major opcodes as full 7-bit fields
	localparam logic [6:0] opc_load = 7'b0000011;
	localparam logic [6:0] opc_opimm = 7'b0010011;
	localparam logic [6:0] opc_store = 7'b0100011;
	localparam logic [6:0] opc_op = 7'b0110011;
	localparam logic [6:0] opc_lui = 7'b0110111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_jalr = 7'b1100111;
	localparam logic [6:0] opc_jal = 7'b1101111;
	localparam logic [6:0] opc_system = 7'b1110011;

	logic clk;
	logic rst;
	logic valid_in;
	rv_isa_pkg::insn_t insn_in;
	logic valid_out;
	rv_isa_pkg::insn_t insn_out;
	logic illegal_out;
	logic compressed_out;

	// expected results in issue order with the issue time
	rv_isa_pkg::insn_t exp_insn_q[$];
	bit exp_ill_q[$];
	bit exp_comp_q[$];
	time stamp_q[$];

	logic [31:0] rng_state;
	rv_isa_pkg::insn_t last_insn;
	bit last_ill;
	bit last_comp;
	bit seen_output;
	int checks;
	int mismatches;
	int other_errors;
	int timeouts;
	int wait_cycles;

	tb_clock u_clock (
		.clk_o(clk)
	);

	rv_decompressor dut (
		.clk_i(clk),
		.rst_i(rst),
		.valid_i(valid_in),
		.insn_i(insn_in),
		.valid_o(valid_out),
		.insn_o(insn_out),
		.illegal_o(illegal_out),
		.compressed_o(compressed_out)
	);

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// base ISA layouts
	function automatic rv_isa_pkg::insn_t r_type_word(input logic [6:0] f7,
			input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3,
			input logic [4:0] rd, input logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic rv_isa_pkg::insn_t i_type_word(input logic [11:0] imm,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
			input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic rv_isa_pkg::insn_t s_type_word(input logic [11:0] imm,
			input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3,
			input logic [6:0] op);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
	endfunction

	// byte offset with bit 0 dropped
	function automatic rv_isa_pkg::insn_t b_type_word(input logic [12:0] ofs,
			input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3,
			input logic [6:0] op);
		return {ofs[12], ofs[10:5], rs2, rs1, f3, ofs[4:1], ofs[11], op};
	endfunction

	function automatic rv_isa_pkg::insn_t u_type_word(input logic [19:0] imm,
			input logic [4:0] rd, input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic rv_isa_pkg::insn_t j_type_word(input logic [20:0] ofs,
			input logic [4:0] rd, input logic [6:0] op);
		return {ofs[20], ofs[10:1], ofs[11], ofs[19:12], rd, op};
	endfunction

	task automatic check_insn(input string name, input rv_isa_pkg::insn_t exp_val,
			input rv_isa_pkg::insn_t act_val);
		checks++;
		if (act_val !== exp_val) begin
			mismatches++;
			$display("Mismatch at %0t: %s expected %h got %h", $time, name, exp_val, act_val);
		end
	endtask

	task automatic check_flag(input string name, input bit exp_val, input logic act_val);
		checks++;
		if (act_val !== exp_val) begin
			mismatches++;
			$display("Mismatch at %0t: %s expected %b got %b", $time, name, exp_val, act_val);
		end
	endtask

	// random fields for one kind plus the expected word
	task automatic build_case(input kind_e kind, output rv_isa_pkg::insn_t word,
			output rv_isa_pkg::insn_t want, output bit want_ill);
		logic [31:0] r;
		logic [31:0] r2;
		logic [15:0] c;
		logic [2:0] rp1;
		logic [2:0] rp2;
		logic [4:0] p1;
		logic [4:0] p2;
		logic [4:0] rd;
		logic [4:0] rdn;
		logic [4:0] rs2n;
		logic [5:0] imm6;
		logic [5:0] nz6;
		logic [11:0] sx6;
		logic [4:0] sh5;
		logic [6:0] u7;
		logic [7:0] o8;
		logic [8:0] o9;
		logic [9:0] u10;
		logic [9:0] sp10;
		logic [11:0] o12;
		logic [2:0] f3q;
		logic [1:0] f2;
		logic [2:0] f3;
		r = xorshift32();
		r2 = xorshift32();
		rp1 = r[2:0];
		rp2 = r[5:3];
		// prime registers live in x8..x15
		p1 = {2'b01, rp1};
		p2 = {2'b01, rp2};
		rd = r[10:6];
		rdn = (rd == 5'd0) ? 5'd1 : rd;
		rs2n = (r[15:11] == 5'd0) ? 5'd7 : r[15:11];
		imm6 = r[21:16];
		nz6 = (imm6 == 6'd0) ? 6'd1 : imm6;
		sx6 = {{6{imm6[5]}}, imm6};
		sh5 = r2[4:0];
		u7 = {r2[4:0], 2'b00};
		o8 = {r2[5:0], 2'b00};
		o9 = {r2[7:0], 1'b0};
		u10 = (r2[7:0] == 8'd0) ? 10'h3fc : {r2[7:0], 2'b00};
		sp10 = {nz6, 4'b0000};
		o12 = {r2[10:0], 1'b0};
		// the fp slots all have bit 13 set
		f3q = {r2[4:3], 1'b1};
		f2 = 2'(int'(kind) - int'(k_sub));
		c = '0;
		want = '0;
		want_ill = 1'b0;
		case (kind)
			k_full: want = {r2[31:2], 2'b11};
			// quadrant 0
			k_addi4spn: begin
				c = {3'b000, u10[5:4], u10[9:6], u10[2], u10[3], rp2, 2'b00};
				want = i_type_word({2'b00, u10}, 5'd2, 3'b000, p2, opc_opimm);
			end
			k_lw: begin
				c = {3'b010, u7[5:3], rp1, u7[2], u7[6], rp2, 2'b00};
				want = i_type_word({5'b0, u7}, p1, 3'b010, p2, opc_load);
			end
			k_sw: begin
				c = {3'b110, u7[5:3], rp1, u7[2], u7[6], rp2, 2'b00};
				want = s_type_word({5'b0, u7}, p2, p1, 3'b010, opc_store);
			end
			// quadrant 1
			k_addi: begin
				c = {3'b000, imm6[5], rd, imm6[4:0], 2'b01};
				want = i_type_word(sx6, rd, 3'b000, rd, opc_opimm);
			end
			k_li: begin
				c = {3'b010, imm6[5], rd, imm6[4:0], 2'b01};
				want = i_type_word(sx6, 5'd0, 3'b000, rd, opc_opimm);
			end
			k_jal, k_j: begin
				c = {(kind == k_jal) ? 3'b001 : 3'b101, o12[11], o12[4], o12[9:8], o12[10],
					o12[6], o12[7], o12[3:1], o12[5], 2'b01};
				want = j_type_word({{9{o12[11]}}, o12}, (kind == k_jal) ? 5'd1 : 5'd0,
					opc_jal);
			end
			k_addi16sp: begin
				c = {3'b011, sp10[9], 5'd2, sp10[4], sp10[6], sp10[8:7], sp10[5], 2'b01};
				want = i_type_word({{2{sp10[9]}}, sp10}, 5'd2, 3'b000, 5'd2, opc_opimm);
			end
			// rd of 2 would select addi16sp
			k_lui: begin
				if (rd == 5'd2) begin
					rd = 5'd3;
				end
				c = {3'b011, nz6[5], rd, nz6[4:0], 2'b01};
				want = u_type_word({{14{nz6[5]}}, nz6}, rd, opc_lui);
			end
			k_srli, k_srai: begin
				c = {3'b100, 1'b0, (kind == k_srai) ? 2'b01 : 2'b00, rp1, sh5, 2'b01};
				want = i_type_word({(kind == k_srai) ? 7'b0100000 : 7'b0000000, sh5},
					p1, 3'b101, p1, opc_opimm);
			end
			k_andi: begin
				c = {3'b100, imm6[5], 2'b10, rp1, imm6[4:0], 2'b01};
				want = i_type_word(sx6, p1, 3'b111, p1, opc_opimm);
			end
			k_sub, k_xor, k_or, k_and: begin
				case (f2)
					2'b00: f3 = 3'b000;
					2'b01: f3 = 3'b100;
					2'b10: f3 = 3'b110;
					default: f3 = 3'b111;
				endcase
				c = {3'b100, 1'b0, 2'b11, rp1, f2, rp2, 2'b01};
				want = r_type_word((f2 == 2'b00) ? 7'b0100000 : 7'b0000000, p2, p1, f3, p1,
					opc_op);
			end
			k_beqz, k_bnez: begin
				c = {(kind == k_beqz) ? 3'b110 : 3'b111, o9[8], o9[4:3], rp1, o9[7:6],
					o9[2:1], o9[5], 2'b01};
				want = b_type_word({{4{o9[8]}}, o9}, 5'd0, p1,
					(kind == k_beqz) ? 3'b000 : 3'b001, opc_branch);
			end
			// quadrant 2 with shamt kept below 32
			k_slli: begin
				c = {3'b000, 1'b0, rd, sh5, 2'b10};
				want = i_type_word({7'b0, sh5}, rd, 3'b001, rd, opc_opimm);
			end
			k_lwsp: begin
				c = {3'b010, o8[5], rdn, o8[4:2], o8[7:6], 2'b10};
				want = i_type_word({4'b0, o8}, 5'd2, 3'b010, rdn, opc_load);
			end
			k_swsp: begin
				c = {3'b110, o8[5:2], o8[7:6], rs2n, 2'b10};
				want = s_type_word({4'b0, o8}, rs2n, 5'd2, 3'b010, opc_store);
			end
			k_jr, k_jalr: begin
				c = {3'b100, (kind == k_jalr), rdn, 5'd0, 2'b10};
				want = i_type_word(12'd0, rdn, 3'b000, (kind == k_jalr) ? 5'd1 : 5'd0,
					opc_jalr);
			end
			k_mv, k_add: begin
				c = {3'b100, (kind == k_add), rdn, rs2n, 2'b10};
				want = r_type_word(7'b0, rs2n, (kind == k_add) ? rdn : 5'd0, 3'b000, rdn,
					opc_op);
			end
			k_ebreak: begin
				c = 16'h9002;
				want = i_type_word(12'd1, 5'd0, 3'b000, 5'd0, opc_system);
			end
			// reserved and dropped encodings
			default: begin
				want_ill = 1'b1;
				case (r2[7:5])
					3'd0: c = 16'h0000;
					3'd1: c = {3'b000, 8'b0, rp2, 2'b00};
					3'd2: c = {f3q, r[12:2], 2'b00};
					3'd3: c = {3'b100, r[12:2], 2'b00};
					3'd4: c = {3'b100, 1'b1, 2'b11, rp1, r[17:16], rp2, 2'b01};
					3'd5: c = {3'b100, r[16], 5'd0, rs2n, 2'b10};
					3'd6: c = 16'h8002;
					default: c = {f3q, r[12:2], 2'b10};
				endcase
			end
		endcase
		if (kind == k_full) begin
			word = {r2[31:2], 2'b11};
		end else begin
			word = {r2[31:16], c};
		end
	endtask

	// one valid word driven on the falling edge
	task automatic drive_word(input kind_e kind);
		rv_isa_pkg::insn_t word;
		rv_isa_pkg::insn_t want;
		bit want_ill;
		build_case(kind, word, want, want_ill);
		valid_in = 1'b1;
		insn_in = word;
		exp_insn_q.push_back(want);
		exp_ill_q.push_back(want_ill);
		exp_comp_q.push_back(kind != k_full);
		stamp_q.push_back($time);
	endtask

	// gap cycle with junk on the data bus
	task automatic idle_cycle();
		valid_in = 1'b0;
		insn_in = xorshift32();
	endtask

	// output side sampled on the falling edge
	always @(negedge clk) begin
		if (!rst) begin
			if (valid_out) begin
				if (stamp_q.size() == 0) begin
					other_errors++;
					$display("output at %0t with no word issued", $time);
				end else begin
					if ($time - stamp_q[0] != clk_period) begin
						other_errors++;
						$display("output at %0t arrived %0t after its input", $time,
							$time - stamp_q[0]);
					end
					void'(stamp_q.pop_front());
					check_insn("insn_o", exp_insn_q.pop_front(), insn_out);
					check_flag("illegal_o", exp_ill_q.pop_front(), illegal_out);
					check_flag("compressed_o", exp_comp_q.pop_front(), compressed_out);
				end
				last_insn = insn_out;
				last_ill = illegal_out;
				last_comp = compressed_out;
				seen_output = 1'b1;
			end else begin
				// outputs hold between valid words
				if (seen_output) begin
					check_insn("insn_o held", last_insn, insn_out);
					check_flag("illegal_o held", last_ill, illegal_out);
					check_flag("compressed_o held", last_comp, compressed_out);
				end
				if (stamp_q.size() > 0 && stamp_q[0] + clk_period <= $time) begin
					other_errors++;
					$display("no output at %0t for the word issued at %0t", $time,
						stamp_q[0]);
					void'(stamp_q.pop_front());
					void'(exp_insn_q.pop_front());
					void'(exp_ill_q.pop_front());
					void'(exp_comp_q.pop_front());
				end
			end
		end
	end

	initial begin
		rng_state = 32'd77;
		checks = 0;
		mismatches = 0;
		other_errors = 0;
		timeouts = 0;
		seen_output = 1'b0;
		last_insn = '0;
		last_ill = 1'b0;
		last_comp = 1'b0;
		rst = 1'b1;
		valid_in = 1'b0;
		insn_in = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// idle after reset gives no output
		repeat (4) begin
			check_flag("valid_o", 1'b0, valid_out);
			idle_cycle();
			@(negedge clk);
		end

		// every kind back to back
		for (int k = 0; k < num_kinds; k++) begin
			repeat (8) begin
				drive_word(kind_e'(k));
				@(negedge clk);
			end
		end

		// random stream with about one gap in four
		repeat (600) begin
			if (xorshift32() % 32'd4 == 32'd0) begin
				idle_cycle();
			end else begin
				drive_word(kind_e'(int'(xorshift32() % 32'(num_kinds))));
			end
			@(negedge clk);
		end
		idle_cycle();

		// drain what is still in flight
		wait_cycles = 0;
		while (stamp_q.size() > 0 && wait_cycles < 20) begin
			@(posedge clk);
			wait_cycles++;
		end
		if (stamp_q.size() > 0) begin
			timeouts++;
			$display("timed out with %0d results still outstanding", stamp_q.size());
		end

		$display("checks %0d, mismatches %0d, other errors %0d, timeouts %0d",
			checks, mismatches, other_errors, timeouts);
		if (mismatches == 0 && other_errors == 0 && timeouts == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== all.f ====
design/rv_isa_pkg.sv
design/rvc_pkg.sv
design/rvc_quadrant0.sv
design/rvc_quadrant1.sv
design/rvc_quadrant2.sv
design/rv_insn_encoder.sv
design/rv_decompressor.sv
tests/tb_clock.sv
tests/rv_decompressor_chk.sv
tests/tb_rv_decompressor.sv

// ==== Makefile ====
TOP = tb_rv_decompressor

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir

# the log decides pass or fail
run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
